// File: dv/fpu_checker.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_checker #(
  parameter int MUL_LATENCY = 2
) (
  input logic clk,
  input logic rstn,
  input logic order,
  input logic accepted,
  input logic done,
  input logic mul_accepted,
  input logic mul_done,
  input logic misc_done
);

  int unsigned fire_count = 0;

  // no result during reset or just after it
  assert property (@(posedge clk) !rstn |-> !done)
    else begin $error("done high during reset"); fire_count++; end
  assert property (@(posedge clk) !rstn |=> !done)
    else begin $error("done high right after reset"); fire_count++; end

  // fmul pipeline depth matches the dispatcher's view
  assert property (@(posedge clk) disable iff (!rstn)
    mul_accepted |-> ##MUL_LATENCY mul_done)
    else begin $error("fmul done missing after accept"); fire_count++; end
  assert property (@(posedge clk) disable iff (!rstn)
    mul_done |-> $past(mul_accepted, MUL_LATENCY))
    else begin $error("fmul done without matching accept"); fire_count++; end

  assert property (@(posedge clk) disable iff (!rstn) !(mul_done && misc_done))
    else begin $error("fmul and fmisc done together"); fire_count++; end

  assert property (@(posedge clk) disable iff (!rstn) accepted |-> order)
    else begin $error("accepted without order"); fire_count++; end

endmodule

`default_nettype wire

// File: dv/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD = 4,
  parameter int RESET_CYCLES = 10
) (
  output logic clk,
  output logic rstn
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    rstn = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rstn <= 1'b1;
  end

endmodule

`default_nettype wire

// File: dv/tb_fpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fpu;

  import fpu_pkg::*;

  localparam int MUL_LATENCY = 2;
  localparam int RAND_OPS = 40;

  logic            clk;
  logic            rstn;
  logic            order;
  fpu_op_e         op;
  logic [FLEN-1:0] rs1;
  logic [FLEN-1:0] rs2;
  logic            accepted;
  logic            done;
  logic [FLEN-1:0] rd;

  string           tbl_name[$];
  fpu_op_e         tbl_op[$];
  logic [FLEN-1:0] tbl_a[$];
  logic [FLEN-1:0] tbl_b[$];
  logic [FLEN-1:0] tbl_exp[$];

  logic [FLEN-1:0] results[$];
  logic [31:0]     lfsr_state = 32'd86;
  int              n_tests = 0;
  int              pass_count = 0;
  int              fail_count = 0;
  int              issued = 0;
  int              done_total = 0;

  tb_clk_gen #(.PERIOD(4), .RESET_CYCLES(10)) u_clk (.clk(clk), .rstn(rstn));

  fpu_top #(.MUL_LATENCY(MUL_LATENCY)) uut (
    .clk(clk), .rstn(rstn), .order(order), .op(op), .rs1(rs1), .rs2(rs2),
    .accepted(accepted), .done(done), .rd(rd)
  );

  bind fpu_top fpu_checker #(.MUL_LATENCY(MUL_LATENCY)) u_checker (
    .clk(clk), .rstn(rstn), .order(order), .accepted(accepted), .done(done),
    .mul_accepted(mul_accepted), .mul_done(mul_done), .misc_done(misc_done)
  );

  // every done pulse queues its result
  always @(posedge clk) begin
    if (rstn && done) begin
      results.push_back(rd);
      done_total++;
    end
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  // exponent kept in 100..150
  task automatic rand_operand(output logic [FLEN-1:0] x);
    logic [31:0] s;
    logic [31:0] e;
    logic [31:0] m;
    take_bits(1, s);
    take_bits(6, e);
    take_bits(23, m);
    e = 32'd100 + (e % 32'd51);
    x = {s[0], e[7:0], m[22:0]};
  endtask

  // truncating multiply with flush to denormal below 2^-126
  function automatic logic [FLEN-1:0] fmul_model(input logic [FLEN-1:0] a,
                                                 input logic [FLEN-1:0] b);
    logic        sign;
    int          ea;
    int          eb;
    int          esum;
    int          lz;
    int          e;
    logic [23:0] sa;
    logic [23:0] sb;
    logic [47:0] prod;
    logic [47:0] t;
    logic [7:0]  eo;
    sign = a[31] ^ b[31];
    if (a[30:0] == 31'd0 || b[30:0] == 31'd0) begin
      return {sign, 31'd0};
    end
    ea = (a[30:23] == 8'd0) ? 1 : int'(a[30:23]);
    eb = (b[30:23] == 8'd0) ? 1 : int'(b[30:23]);
    sa = {a[30:23] != 8'd0, a[22:0]};
    sb = {b[30:23] != 8'd0, b[22:0]};
    prod = {24'd0, sa} * {24'd0, sb};
    esum = ea + eb;
    if (esum < 128) begin
      t = prod >> (127 - esum);
      eo = (esum == 127 && prod[47]) ? 8'd1 : 8'd0;
      return {sign, eo, t[46:24]};
    end
    lz = 0;
    while (lz < 48 && !prod[47 - lz]) begin
      lz++;
    end
    e = esum - 126 - lz;
    if (e > 0) begin
      t = prod << lz;
      return {sign, e[7:0], t[46:24]};
    end
    t = prod << (esum - 127);
    return {sign, 8'd0, t[46:24]};
  endfunction

  task automatic add_vec(input string name, input fpu_op_e o, input logic [FLEN-1:0] a,
                         input logic [FLEN-1:0] b, input logic [FLEN-1:0] expv);
    tbl_name.push_back(name);
    tbl_op.push_back(o);
    tbl_a.push_back(a);
    tbl_b.push_back(b);
    tbl_exp.push_back(expv);
  endtask

  task automatic load_table();
    add_vec("fmul 1.5*2.0", op_fmul, 32'h3FC00000, 32'h40000000, 32'h40400000);
    add_vec("fmul 3.0*-1.25", op_fmul, 32'h40400000, 32'hBFA00000, 32'hC0700000);
    add_vec("fmul truncate", op_fmul, 32'h3FC00001, 32'h3FC00001, 32'h40100001);
    add_vec("fmul +0*5.0", op_fmul, 32'h00000000, 32'h40A00000, 32'h00000000);
    add_vec("fmul -0*5.0", op_fmul, 32'h80000000, 32'h40A00000, 32'h80000000);
    add_vec("fmul underflow", op_fmul, 32'h1E000000, 32'h1E400000, 32'h0000C000);
    add_vec("fsgnj neg", op_fsgnj, 32'h40400000, 32'hBF800000, 32'hC0400000);
    add_vec("fsgnj pos", op_fsgnj, 32'hC0400000, 32'h3F800000, 32'h40400000);
    add_vec("fsgnjn", op_fsgnjn, 32'h40400000, 32'hBF800000, 32'h40400000);
    add_vec("fsgnjx", op_fsgnjx, 32'hC0400000, 32'hBF800000, 32'h40400000);
    add_vec("feq equal", op_feq, 32'h40400000, 32'h40400000, 32'h00000001);
    add_vec("feq differ", op_feq, 32'h40400000, 32'h3F800000, 32'h00000000);
    add_vec("flt less", op_flt, 32'h3F800000, 32'h40400000, 32'h00000001);
    add_vec("flt greater", op_flt, 32'h40400000, 32'h3F800000, 32'h00000000);
    add_vec("fle equal", op_fle, 32'h40400000, 32'h40400000, 32'h00000001);
    add_vec("flt negatives", op_flt, 32'hC0400000, 32'hBF800000, 32'h00000001);
    add_vec("fle negatives", op_fle, 32'hBF800000, 32'hC0400000, 32'h00000000);
    add_vec("feq +0 -0", op_feq, 32'h00000000, 32'h80000000, 32'h00000001);
    add_vec("flt -0 +0", op_flt, 32'h80000000, 32'h00000000, 32'h00000000);
    add_vec("fle -0 +0", op_fle, 32'h80000000, 32'h00000000, 32'h00000001);
    add_vec("flt mixed sign", op_flt, 32'hBF800000, 32'h3F800000, 32'h00000001);
  endtask

  // called right after a rising edge; returns on the accepting edge
  task automatic issue(input fpu_op_e o, input logic [FLEN-1:0] a, input logic [FLEN-1:0] b);
    order <= 1'b1;
    op <= o;
    rs1 <= a;
    rs2 <= b;
    issued++;
    @(posedge clk);
    while (!accepted) begin
      @(posedge clk);
    end
  endtask

  task automatic collect(input string name, input logic [FLEN-1:0] expv);
    logic [FLEN-1:0] got;
    int              waited;
    waited = 0;
    while (results.size() == 0 && waited < 20) begin
      @(negedge clk);
      waited++;
    end
    if (results.size() == 0) begin
      $display("%s: no done pulse within 20 cycles", name);
      fail_count++;
    end else begin
      got = results.pop_front();
      if (got !== expv) begin
        $display("CHECK FAILED %s expected %08h actual %08h", name, expv, got);
        fail_count++;
      end else begin
        $display("%s: ok (%08h)", name, got);
        pass_count++;
      end
    end
    @(posedge clk);
  endtask

  initial begin
    n_tests = 21 + 2 + RAND_OPS;
    @(posedge rstn);
    repeat (n_tests * 50) @(posedge clk);
    $display("watchdog expired before all tests finished");
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    logic [FLEN-1:0] a;
    logic [FLEN-1:0] b;
    order <= 1'b0;
    op <= op_fmul;
    rs1 <= '0;
    rs2 <= '0;
    load_table();
    @(posedge rstn);
    @(posedge clk);

    for (int i = 0; i < tbl_name.size(); i++) begin
      issue(tbl_op[i], tbl_a[i], tbl_b[i]);
      order <= 1'b0;
      collect(tbl_name[i], tbl_exp[i]);
    end

    // fsgnj right behind an fmul has to wait for the collision slot
    issue(op_fmul, 32'h40400000, 32'h40000000);
    issue(op_fsgnj, 32'h3F800000, 32'h80000000);
    order <= 1'b0;
    collect("concurrent fmul", fmul_model(32'h40400000, 32'h40000000));
    collect("concurrent fsgnj", 32'hBF800000);

    for (int k = 0; k < RAND_OPS; k++) begin
      rand_operand(a);
      rand_operand(b);
      issue(op_fmul, a, b);
      order <= 1'b0;
      collect($sformatf("random fmul %0d", k), fmul_model(a, b));
    end

    repeat (5) @(posedge clk);
    if (results.size() != 0 || done_total != issued) begin
      $display("done pulses %0d do not match issued orders %0d", done_total, issued);
      fail_count++;
    end
    fail_count += int'(uut.u_checker.fire_count);
    $display("tests passed %0d failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: fpu_top.f
hdl/fpu_pkg.sv
hdl/fmul.sv
hdl/fmisc.sv
hdl/fpu_dispatch.sv
hdl/fpu_top.sv
dv/fpu_checker.sv
dv/tb_clk_gen.sv
dv/tb_fpu.sv

// File: hdl/fmisc.sv
`timescale 1ns/1ps
`default_nettype none

module fmisc (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     order,
  input  fpu_pkg::fpu_op_e         op,
  input  logic [fpu_pkg::FLEN-1:0] rs1,
  input  logic [fpu_pkg::FLEN-1:0] rs2,
  output logic                     accepted,
  output logic                     done,
  output logic [fpu_pkg::FLEN-1:0] rd
);

  import fpu_pkg::*;

  logic            busy;
  logic            s1;
  logic            s2;
  logic [FLEN-2:0] mag1;
  logic [FLEN-2:0] mag2;
  logic            both_zero;
  logic            eq;
  logic            lt;
  logic [FLEN-1:0] result;

  assign accepted = ~busy & order;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      busy <= 1'b0;
    end else if (busy) begin
      busy <= ~done;
    end else begin
      busy <= order;
    end
  end

  assign s1 = rs1[FLEN-1];
  assign s2 = rs2[FLEN-1];
  assign mag1 = rs1[FLEN-2:0];
  assign mag2 = rs2[FLEN-2:0];

  // +0 and -0 compare equal
  assign both_zero = (mag1 == '0) && (mag2 == '0);
  assign eq = both_zero || (rs1 == rs2);

  // sign-magnitude ordering, negatives reverse the magnitude test
  always_comb begin
    if (both_zero) begin
      lt = 1'b0;
    end else if (s1 != s2) begin
      lt = s1;
    end else if (s1) begin
      lt = mag1 > mag2;
    end else begin
      lt = mag1 < mag2;
    end
  end

  always_comb begin
    case (op)
      op_fsgnj:  result = {s2, mag1};
      op_fsgnjn: result = {~s2, mag1};
      op_fsgnjx: result = {s1 ^ s2, mag1};
      op_feq:    result = FLEN'(eq);
      op_flt:    result = FLEN'(lt);
      op_fle:    result = FLEN'(lt | eq);
      default:   result = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      done <= 1'b0;
      rd   <= '0;
    end else begin
      done <= accepted;
      if (accepted) begin
        rd <= result;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/fmul.sv
`timescale 1ns/1ps
`default_nettype none

module fmul (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     order,
  input  logic [fpu_pkg::FLEN-1:0] rs1,
  input  logic [fpu_pkg::FLEN-1:0] rs2,
  output logic                     accepted,
  output logic                     done,
  output logic [fpu_pkg::FLEN-1:0] rd
);

  import fpu_pkg::*;

  localparam int SIG_W = MAN_W + 1;
  localparam int PROD_W = 2 * SIG_W;
  localparam int SE_W = $clog2(PROD_W + 1);

  logic busy;
  logic stage_1;
  logic stage_2;

  // set on order when idle and clear on the done cycle
  always_ff @(posedge clk) begin
    if (!rstn) begin
      busy <= 1'b0;
    end else if (busy) begin
      busy <= ~done;
    end else begin
      busy <= order;
    end
  end

  assign accepted = ~busy & order;
  assign done = stage_2;

  logic             s1;
  logic             s2;
  logic [EXP_W-1:0] e1;
  logic [EXP_W-1:0] e2;
  logic [MAN_W-1:0] m1;
  logic [MAN_W-1:0] m2;
  logic [EXP_W-1:0] e1a;
  logic [EXP_W-1:0] e2a;
  logic [SIG_W-1:0] m1a;
  logic [SIG_W-1:0] m2a;
  logic [EXP_W:0]   esum;
  logic [EXP_W:0]   shifts;
  logic             zero_in;

  assign s1 = rs1[FLEN-1];
  assign s2 = rs2[FLEN-1];
  assign e1 = rs1[FLEN-2 -: EXP_W];
  assign e2 = rs2[FLEN-2 -: EXP_W];
  assign m1 = rs1[MAN_W-1:0];
  assign m2 = rs2[MAN_W-1:0];

  // denormals count as exponent one without the hidden bit
  assign e1a = (e1 == '0) ? EXP_W'(1) : e1;
  assign e2a = (e2 == '0) ? EXP_W'(1) : e2;
  assign m1a = {e1 != '0, m1};
  assign m2a = {e2 != '0, m2};

  assign esum = {1'b0, e1a} + {1'b0, e2a};
  // right shift used only when the sum falls below the bias
  assign shifts = (EXP_W + 1)'(EXP_BIAS) - esum;
  assign zero_in = ((e1 == '0) && (m1 == '0)) || ((e2 == '0) && (m2 == '0));

  logic             sy_1;
  logic [EXP_W:0]   esum_1;
  logic [EXP_W:0]   shifts_1;
  logic [SIG_W-1:0] m1a_1;
  logic [SIG_W-1:0] m2a_1;
  logic             zero_1;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      stage_1 <= 1'b0;
    end else begin
      stage_1 <= accepted;
    end
  end

  always_ff @(posedge clk) begin
    if (accepted) begin
      sy_1     <= s1 ^ s2;
      esum_1   <= esum;
      shifts_1 <= shifts;
      m1a_1    <= m1a;
      m2a_1    <= m2a;
      zero_1   <= zero_in;
    end
  end

  logic [PROD_W-1:0] myd;
  logic [SE_W-1:0]   se;

  assign myd = PROD_W'(m1a_1) * PROD_W'(m2a_1);

  // leading zero count of the raw product
  always_comb begin
    se = SE_W'(PROD_W);
    for (int i = 0; i < PROD_W; i++) begin
      if (myd[i]) begin
        se = SE_W'(PROD_W - 1 - i);
      end
    end
  end

  logic              sy_2;
  logic [EXP_W:0]    esum_2;
  logic [EXP_W:0]    shifts_2;
  logic [PROD_W-1:0] myd_2;
  logic [SE_W-1:0]   se_2;
  logic              zero_2;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      stage_2  <= 1'b0;
      sy_2     <= 1'b0;
      esum_2   <= '0;
      shifts_2 <= '0;
      myd_2    <= '0;
      se_2     <= '0;
      zero_2   <= 1'b0;
    end else begin
      stage_2 <= stage_1;
      if (stage_1) begin
        sy_2     <= sy_1;
        esum_2   <= esum_1;
        shifts_2 <= shifts_1;
        myd_2    <= myd;
        se_2     <= se;
        zero_2   <= zero_1;
      end
    end
  end

  logic [EXP_W-1:0]   eyd;
  logic signed [EXP_W:0] eyf;
  logic               norm_ok;
  logic [EXP_W-1:0]   eyr;
  logic [PROD_W-1:0]  myf;
  logic [PROD_W-1:0]  myd_shr;
  logic               udf;
  logic               udf_just;
  logic [EXP_W-1:0]   ey;
  logic [MAN_W-1:0]   my;

  // product has two integer bits so the bias drops by one
  assign eyd = esum_2[EXP_W-1:0] - EXP_W'(EXP_BIAS - 1);
  assign eyf = {1'b0, eyd} - (EXP_W + 1)'(se_2);
  assign norm_ok = eyf > 0;
  assign eyr = norm_ok ? eyf[EXP_W-1:0] : '0;
  assign myf = norm_ok ? (myd_2 << se_2) : (myd_2 << (eyd[4:0] - 5'd1));
  assign myd_shr = myd_2 >> shifts_2;

  assign udf = esum_2 < (EXP_W + 1)'(EXP_BIAS + 1);
  assign udf_just = esum_2 == (EXP_W + 1)'(EXP_BIAS);

  // exactly at the bias a carry into bit 47 still gives exponent one
  assign ey = (udf_just && myd_2[PROD_W-1]) ? EXP_W'(1) :
              udf ? '0 : eyr;
  assign my = udf ? myd_shr[PROD_W-2 -: MAN_W] : myf[PROD_W-2 -: MAN_W];

  assign rd = zero_2 ? {sy_2, (FLEN - 1)'(0)} : {sy_2, ey, my};

endmodule

`default_nettype wire

// File: hdl/fpu_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_dispatch #(
  parameter int MUL_LATENCY = 2
) (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     order,
  input  fpu_pkg::fpu_op_e         op,
  output logic                     accepted,
  output logic                     mul_order,
  input  logic                     mul_accepted,
  input  logic                     mul_done,
  input  logic [fpu_pkg::FLEN-1:0] mul_rd,
  output logic                     misc_order,
  input  logic                     misc_accepted,
  input  logic                     misc_done,
  input  logic [fpu_pkg::FLEN-1:0] misc_rd,
  output logic                     done,
  output logic [fpu_pkg::FLEN-1:0] rd
);

  import fpu_pkg::*;

  // fmisc finishes one cycle after accept
  localparam int HIST_W = MUL_LATENCY - 1;

  logic              to_mul;
  logic              to_misc;
  logic [HIST_W-1:0] mul_hist;
  logic              misc_block;

  assign to_mul = (op == op_fmul);
  assign to_misc = op inside {op_fsgnj, op_fsgnjn, op_fsgnjx, op_feq, op_flt, op_fle};

  // recent fmul accepts, oldest at the top
  always_ff @(posedge clk) begin
    if (!rstn) begin
      mul_hist <= '0;
    end else begin
      mul_hist[0] <= mul_accepted;
      for (int i = 1; i < HIST_W; i++) begin
        mul_hist[i] <= mul_hist[i-1];
      end
    end
  end

  // an fmisc accept now would land on that fmul's done cycle
  assign misc_block = mul_hist[HIST_W-1];

  assign mul_order = order & to_mul;
  assign misc_order = order & to_misc & ~misc_block;

  // only one unit ever sees an order
  assign accepted = mul_accepted | misc_accepted;

  assign done = mul_done | misc_done;
  assign rd = mul_done ? mul_rd : misc_rd;

endmodule

`default_nettype wire

// File: hdl/fpu_pkg.sv
`default_nettype none

package fpu_pkg;

  // operand and result width
  localparam int FLEN = 32;

  // single-precision field layout
  localparam int EXP_W = 8;
  localparam int MAN_W = 23;
  localparam int EXP_BIAS = 127;

  // issue port operation codes
  typedef enum logic [2:0] {
    // goes to the multiplier
    op_fmul   = 3'd0,
    // sign injection, rs1 magnitude
    op_fsgnj  = 3'd1,
    op_fsgnjn = 3'd2,
    op_fsgnjx = 3'd3,
    // comparisons return 1 or 0
    op_feq    = 3'd4,
    op_flt    = 3'd5,
    op_fle    = 3'd6
  } fpu_op_e;

endpackage

`default_nettype wire

// File: hdl/fpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_top #(
  parameter int MUL_LATENCY = 2
) (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     order,
  input  fpu_pkg::fpu_op_e         op,
  input  logic [fpu_pkg::FLEN-1:0] rs1,
  input  logic [fpu_pkg::FLEN-1:0] rs2,
  output logic                     accepted,
  output logic                     done,
  output logic [fpu_pkg::FLEN-1:0] rd
);

  import fpu_pkg::*;

  logic            mul_order;
  logic            mul_accepted;
  logic            mul_done;
  logic [FLEN-1:0] mul_rd;
  logic            misc_order;
  logic            misc_accepted;
  logic            misc_done;
  logic [FLEN-1:0] misc_rd;

  fpu_dispatch #(
    .MUL_LATENCY(MUL_LATENCY)
  ) u_dispatch (
    .clk          (clk),
    .rstn         (rstn),
    .order        (order),
    .op           (op),
    .accepted     (accepted),
    .mul_order    (mul_order),
    .mul_accepted (mul_accepted),
    .mul_done     (mul_done),
    .mul_rd       (mul_rd),
    .misc_order   (misc_order),
    .misc_accepted(misc_accepted),
    .misc_done    (misc_done),
    .misc_rd      (misc_rd),
    .done         (done),
    .rd           (rd)
  );

  fmul u_fmul (
    .clk     (clk),
    .rstn    (rstn),
    .order   (mul_order),
    .rs1     (rs1),
    .rs2     (rs2),
    .accepted(mul_accepted),
    .done    (mul_done),
    .rd      (mul_rd)
  );

  fmisc u_fmisc (
    .clk     (clk),
    .rstn    (rstn),
    .order   (misc_order),
    .op      (op),
    .rs1     (rs1),
    .rs2     (rs2),
    .accepted(misc_accepted),
    .done    (misc_done),
    .rd      (misc_rd)
  );

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the FPU testbench with Verilator.
# Pass or fail is taken from the simulation output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_fpu \
  -f fpu_top.f --Mdir obj_dir -o tb_fpu_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_fpu_sim +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "RESULT: PASS"; then
  exit 0
fi
exit 1
